// File: Bender.yml
package:
  name: wasm_mem

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/wasm_bus_pkg.sv
      - hw/wasm_mgmt_pkg.sv
      - hw/wasm_page_ctrl.sv
      - hw/wasm_mem_access.sv
      - hw/wasm_byte_store.sv
      - hw/wasm_load_extend.sv
      - hw/wasm_mem_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_clock_gen.sv
      - test/tb_wasm_mem.sv

// File: build.f
+incdir+hw
hw/wasm_bus_pkg.sv
hw/wasm_mgmt_pkg.sv
hw/wasm_page_ctrl.sv
hw/wasm_mem_access.sv
hw/wasm_byte_store.sv
hw/wasm_load_extend.sv
hw/wasm_mem_top.sv
test/tb_clock_gen.sv
test/tb_wasm_mem.sv

// File: hw/wasm_bus_pkg.sv
// Data bus types for the linear memory
// Address and data vectors, access size and load kind, request and response

`include "wasm_mem_params.svh"

package wasm_bus_pkg;

    typedef logic [`WASM_ADDR_W-1:0] addr_t;
    typedef logic [`WASM_DATA_W-1:0] data_t;

    // One enable bit per byte lane of data_t
    typedef logic [`WASM_DATA_W/8-1:0] byte_mask_t;

    // Store width
    typedef enum logic [1:0] {
        SIZE_1 = 2'd0,
        SIZE_2 = 2'd1,
        SIZE_4 = 2'd2,
        SIZE_8 = 2'd3
    } mem_size_e;

    // Load kind, selects width and extension
    typedef enum logic [2:0] {
        LOAD_I32   = 3'd0,
        LOAD_I64   = 3'd1,
        LOAD_I8_S  = 3'd2,
        LOAD_I8_U  = 3'd3,
        LOAD_I16_S = 3'd4,
        LOAD_I16_U = 3'd5,
        LOAD_I32_S = 3'd6,
        LOAD_I32_U = 3'd7
    } load_op_e;

    typedef struct packed {
        logic      valid;
        logic      write;
        addr_t     addr;
        data_t     wdata;
        mem_size_e size;
        load_op_e  op;
    } mem_req_t;

    typedef struct packed {
        data_t rdata;
        logic  rvalid;
        logic  error;
    } mem_resp_t;

endpackage

// File: hw/wasm_byte_store.sv
// Byte-addressed backing array
// Masked little-endian writes, combinational 8-byte read, cleared on reset

`include "wasm_mem_params.svh"

module wasm_byte_store
    import wasm_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en_i,
    input  addr_t      addr_i,
    input  data_t      wdata_i,
    input  byte_mask_t byte_mask_i,
    output data_t      rdata_o
);

    localparam int unsigned LANES = $bits(byte_mask_t);
    localparam int unsigned IDX_W = $clog2(`WASM_MEM_BYTES);

    logic [7:0]  mem [`WASM_MEM_BYTES];
    logic [32:0] lane_addr [LANES];
    logic        lane_hit  [LANES];

    // Address of each lane and whether it falls inside the array
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_addr[l] = {1'b0, addr_i} + 33'(l);
            lane_hit[l]  = lane_addr[l] < 33'(`WASM_MEM_BYTES);
            rdata_o[8*l +: 8] = lane_hit[l] ? mem[lane_addr[l][IDX_W-1:0]] : 8'h00;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WASM_MEM_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (wr_en_i) begin
            for (int l = 0; l < LANES; l++) begin
                if (byte_mask_i[l] && lane_hit[l]) begin
                    mem[lane_addr[l][IDX_W-1:0]] <= wdata_i[8*l +: 8];
                end
            end
        end
    end

endmodule

// File: hw/wasm_load_extend.sv
// Load result formatting
// Keeps the low bytes selected by the load op and sign- or zero-extends them

module wasm_load_extend
    import wasm_bus_pkg::*;
(
    input  data_t    raw_i,
    input  load_op_e load_op_i,
    input  logic     load_ok_i,
    output data_t    rdata_o,
    output logic     rvalid_o
);

    data_t extended;

    always_comb begin
        case (load_op_i)
            LOAD_I64:   extended = raw_i;
            LOAD_I8_S:  extended = {{56{raw_i[7]}}, raw_i[7:0]};
            LOAD_I8_U:  extended = {56'd0, raw_i[7:0]};
            LOAD_I16_S: extended = {{48{raw_i[15]}}, raw_i[15:0]};
            LOAD_I16_U: extended = {48'd0, raw_i[15:0]};
            LOAD_I32_S: extended = {{32{raw_i[31]}}, raw_i[31:0]};
            // Plain i32 and i32 unsigned both zero-extend
            default:    extended = {32'd0, raw_i[31:0]};
        endcase
    end

    // Failed or absent loads return zero
    assign rdata_o  = load_ok_i ? extended : '0;
    assign rvalid_o = load_ok_i;

endmodule

// File: hw/wasm_mem_access.sv
// Access decode for the linear memory
// Width decode, bounds check against the declared size, byte mask, error

module wasm_mem_access
    import wasm_bus_pkg::*;
    import wasm_mgmt_pkg::*;
(
    input  mem_req_t   mem_req_i,
    input  mem_limit_t mem_limit_i,
    output logic       wr_en_o,
    output addr_t      addr_o,
    output data_t      wdata_o,
    output byte_mask_t byte_mask_o,
    output logic       load_ok_o,
    output load_op_e   load_op_o,
    output logic       error_o
);

    logic [3:0]  width;
    logic [3:0]  store_width;
    logic [3:0]  load_width;
    logic [33:0] end_addr;
    logic        in_bounds;

    // Store width and its lane mask
    always_comb begin
        case (mem_req_i.size)
            SIZE_1:  begin store_width = 4'd1; byte_mask_o = 8'h01; end
            SIZE_2:  begin store_width = 4'd2; byte_mask_o = 8'h03; end
            SIZE_4:  begin store_width = 4'd4; byte_mask_o = 8'h0F; end
            default: begin store_width = 4'd8; byte_mask_o = 8'hFF; end
        endcase
    end

    // Load width follows the op
    always_comb begin
        case (mem_req_i.op)
            LOAD_I8_S, LOAD_I8_U:   load_width = 4'd1;
            LOAD_I16_S, LOAD_I16_U: load_width = 4'd2;
            LOAD_I64:               load_width = 4'd8;
            default:                load_width = 4'd4;
        endcase
    end

    assign width = mem_req_i.write ? store_width : load_width;

    // Top bit flags a carry past 33 bits
    assign end_addr  = {2'b00, mem_req_i.addr} + {30'd0, width};
    assign in_bounds = !end_addr[33] && (end_addr[32:0] <= mem_limit_i);

    assign wr_en_o   = mem_req_i.valid && mem_req_i.write && in_bounds;
    assign load_ok_o = mem_req_i.valid && !mem_req_i.write && in_bounds;
    assign error_o   = mem_req_i.valid && !in_bounds;

    assign addr_o    = mem_req_i.addr;
    assign wdata_o   = mem_req_i.wdata;
    assign load_op_o = mem_req_i.op;

endmodule

// File: hw/wasm_mem_params.svh
// Sizing constants for the WebAssembly linear memory
// Page geometry, bus widths and the grow failure code

`ifndef WASM_MEM_PARAMS_SVH
`define WASM_MEM_PARAMS_SVH

// Page size kept small so the backing array stays compact
`define WASM_PAGE_BYTES 256

// Physical page limit of the backing store
`define WASM_MAX_PAGES 4

`define WASM_MEM_BYTES (`WASM_PAGE_BYTES * `WASM_MAX_PAGES)

// Bus widths
`define WASM_ADDR_W 32
`define WASM_DATA_W 64

// Management widths, limit needs one extra bit to express 4 GB
`define WASM_PAGE_CNT_W 32
`define WASM_LIMIT_W 33

// memory.grow returns -1 on failure
`define WASM_GROW_FAIL 32'hFFFF_FFFF

`endif

// File: hw/wasm_mem_top.sv
// Linear memory top level
// Connects page control, access decode, byte store and load formatting

module wasm_mem_top
    import wasm_bus_pkg::*;
    import wasm_mgmt_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  mem_req_t   mem_req_i,
    input  mgmt_req_t  mgmt_req_i,
    output mem_resp_t  mem_resp_o,
    output mgmt_resp_t mgmt_resp_o
);

    mem_limit_t mem_limit;
    logic       wr_en;
    addr_t      addr;
    data_t      wdata;
    byte_mask_t byte_mask;
    logic       load_ok;
    load_op_e   load_op;
    logic       error;
    data_t      raw;

    wasm_page_ctrl u_page_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .mgmt_req_i  (mgmt_req_i),
        .mgmt_resp_o (mgmt_resp_o),
        .mem_limit_o (mem_limit)
    );

    wasm_mem_access u_mem_access (
        .mem_req_i   (mem_req_i),
        .mem_limit_i (mem_limit),
        .wr_en_o     (wr_en),
        .addr_o      (addr),
        .wdata_o     (wdata),
        .byte_mask_o (byte_mask),
        .load_ok_o   (load_ok),
        .load_op_o   (load_op),
        .error_o     (error)
    );

    wasm_byte_store u_byte_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en_i     (wr_en),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .byte_mask_i (byte_mask),
        .rdata_o     (raw)
    );

    wasm_load_extend u_load_extend (
        .raw_i     (raw),
        .load_op_i (load_op),
        .load_ok_i (load_ok),
        .rdata_o   (mem_resp_o.rdata),
        .rvalid_o  (mem_resp_o.rvalid)
    );

    assign mem_resp_o.error = error;

endmodule

// File: hw/wasm_mgmt_pkg.sv
// Page management types for the linear memory
// Page count and byte limit vectors, management request and response

`include "wasm_mem_params.svh"

package wasm_mgmt_pkg;

    typedef logic [`WASM_PAGE_CNT_W-1:0] page_cnt_t;
    typedef logic [`WASM_LIMIT_W-1:0]    mem_limit_t;

    typedef struct packed {
        logic      init_valid;
        page_cnt_t init_pages;
        page_cnt_t init_max_pages;  // zero selects the physical limit
        logic      grow_valid;
        page_cnt_t grow_pages;
    } mgmt_req_t;

    typedef struct packed {
        page_cnt_t current_pages;
        page_cnt_t grow_result;
        logic      grow_done;
    } mgmt_resp_t;

endpackage

// File: hw/wasm_page_ctrl.sv
// Page bookkeeping for the linear memory
// Current and declared maximum page count, memory.grow handling, byte limit

`include "wasm_mem_params.svh"

module wasm_page_ctrl
    import wasm_mgmt_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  mgmt_req_t  mgmt_req_i,
    output mgmt_resp_t mgmt_resp_o,
    output mem_limit_t mem_limit_o
);

    page_cnt_t         num_pages_q;
    page_cnt_t         max_pages_q;
    page_cnt_t         grow_result_q;
    logic              grow_done_q;
    logic [`WASM_PAGE_CNT_W:0] grow_sum;
    logic              grow_ok;
    page_cnt_t         init_max;

    // One extra bit so a huge grow request cannot wrap into range
    assign grow_sum = {1'b0, num_pages_q} + {1'b0, mgmt_req_i.grow_pages};
    assign grow_ok  = (grow_sum <= {1'b0, max_pages_q}) &&
                      (grow_sum <= (`WASM_PAGE_CNT_W+1)'(`WASM_MAX_PAGES));

    assign init_max = (mgmt_req_i.init_max_pages != '0) ? mgmt_req_i.init_max_pages
                                                         : page_cnt_t'(`WASM_MAX_PAGES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_pages_q   <= '0;
            max_pages_q   <= page_cnt_t'(`WASM_MAX_PAGES);
            grow_result_q <= '0;
            grow_done_q   <= 1'b0;
        end else begin
            grow_done_q <= mgmt_req_i.grow_valid;

            if (mgmt_req_i.init_valid) begin
                num_pages_q <= mgmt_req_i.init_pages;
                max_pages_q <= init_max;
            end

            // Grow sees the old count and overrides a same-cycle init
            if (mgmt_req_i.grow_valid) begin
                if (grow_ok) begin
                    grow_result_q <= num_pages_q;
                    num_pages_q   <= grow_sum[`WASM_PAGE_CNT_W-1:0];
                end else begin
                    grow_result_q <= `WASM_GROW_FAIL;
                end
            end
        end
    end

    assign mgmt_resp_o.current_pages = num_pages_q;
    assign mgmt_resp_o.grow_result   = grow_result_q;
    assign mgmt_resp_o.grow_done     = grow_done_q;

    // Declared size in bytes
    assign mem_limit_o = mem_limit_t'(num_pages_q) * mem_limit_t'(`WASM_PAGE_BYTES);

endmodule

// File: test/tb_clock_gen.sv
// Testbench clock and reset source
// Free-running clock, active-low reset held for a few cycles

module tb_clock_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

// File: test/tb_wasm_mem.sv
// Testbench for the linear memory top level
// Byte and page models, LFSR stimulus, assertions, watchdog and reporting

`include "wasm_mem_params.svh"

module tb_wasm_mem
    import wasm_bus_pkg::*;
    import wasm_mgmt_pkg::*;
();

    localparam int PERIOD      = 40;
    localparam int RT_ITERS    = 24;
    // Rough cycle budget of all five tests, doubled for margin
    localparam int TEST_CYCLES = 8 + 12 + 2 * RT_ITERS + 4 * 8 + 16;
    localparam int TIMEOUT     = 2 * TEST_CYCLES * PERIOD;

    logic       clk;
    logic       rst_n;
    mem_req_t   mem_req;
    mgmt_req_t  mgmt_req;
    mem_resp_t  mem_resp;
    mgmt_resp_t mgmt_resp;

    logic [7:0] model_mem [`WASM_MEM_BYTES];
    page_cnt_t  model_pages;
    page_cnt_t  model_max;
    logic [15:0] lfsr_state;
    int         checks;
    int         errors;
    int         test_checks;
    int         test_errors;

    tb_clock_gen #(.PERIOD(PERIOD), .RST_CYCLES(3)) u_clk (.clk(clk), .rst_n(rst_n));

    wasm_mem_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req_i   (mem_req),
        .mgmt_req_i  (mgmt_req),
        .mem_resp_o  (mem_resp),
        .mgmt_resp_o (mgmt_resp)
    );

    task automatic flag_error(string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check(bit ok, string msg);
        checks++;
        assert (ok) else flag_error(msg);
    endtask

    // grow_done must mirror grow_valid one edge later, which makes it a single pulse
    grow_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mgmt_resp.grow_done == $past(mgmt_req.grow_valid))
        else flag_error("grow_done does not follow grow_valid by one cycle");

    // x^16 + x^14 + x^13 + x^11 + 1
    function logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic bit fits(addr_t a, int unsigned w);
        logic [33:0] last;
        logic [33:0] limit;
        last  = {2'b00, a} + 34'(w);
        limit = 34'(model_pages) * 34'(`WASM_PAGE_BYTES);
        return last <= limit;
    endfunction

    function automatic int unsigned op_bytes(load_op_e op);
        case (op)
            LOAD_I8_S, LOAD_I8_U:   return 1;
            LOAD_I16_S, LOAD_I16_U: return 2;
            LOAD_I64:               return 8;
            default:                return 4;
        endcase
    endfunction

    function automatic data_t expect_load(addr_t a, load_op_e op);
        int unsigned n;
        bit          sgn;
        data_t       v;
        n   = op_bytes(op);
        sgn = (op == LOAD_I8_S) || (op == LOAD_I16_S) || (op == LOAD_I32_S);
        v   = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model_mem[a + i];
        end
        if (sgn && v[8*n-1]) begin
            for (int i = n; i < 8; i++) begin
                v[8*i +: 8] = 8'hFF;
            end
        end
        return v;
    endfunction

    task automatic do_store(addr_t a, data_t d, mem_size_e s);
        int unsigned w;
        bit          ok;
        w  = 1 << s;
        ok = fits(a, w);
        @(posedge clk);
        #2;
        mem_req.valid = 1'b1;
        mem_req.write = 1'b1;
        mem_req.addr  = a;
        mem_req.wdata = d;
        mem_req.size  = s;
        @(negedge clk);
        check(mem_resp.error == !ok, "store error flag wrong");
        check(mem_resp.rvalid == 1'b0, "rvalid raised on a store");
        if (ok) begin
            for (int i = 0; i < w; i++) begin
                model_mem[a + i] = d[8*i +: 8];
            end
        end
    endtask

    task automatic do_load(addr_t a, load_op_e op);
        bit    ok;
        data_t exp_data;
        ok       = fits(a, op_bytes(op));
        exp_data = ok ? expect_load(a, op) : '0;
        @(posedge clk);
        #2;
        mem_req.valid = 1'b1;
        mem_req.write = 1'b0;
        mem_req.addr  = a;
        mem_req.op    = op;
        @(negedge clk);
        check(mem_resp.error == !ok, "load error flag wrong");
        check(mem_resp.rvalid == ok, "load rvalid wrong");
        check(mem_resp.rdata == exp_data, $sformatf("load %s at %0d gave %h, expected %h",
              op.name(), a, mem_resp.rdata, exp_data));
    endtask

    task automatic idle();
        @(posedge clk);
        #2;
        mem_req.valid = 1'b0;
    endtask

    task automatic do_init(page_cnt_t pages, page_cnt_t maxp);
        @(posedge clk);
        #2;
        mgmt_req.init_valid     = 1'b1;
        mgmt_req.init_pages     = pages;
        mgmt_req.init_max_pages = maxp;
        @(posedge clk);
        #2;
        mgmt_req.init_valid = 1'b0;
        model_pages = pages;
        model_max   = (maxp == 0) ? page_cnt_t'(`WASM_MAX_PAGES) : maxp;
        @(negedge clk);
        check(mgmt_resp.current_pages == model_pages, "page count wrong after init");
    endtask

    task automatic do_grow(page_cnt_t n);
        logic [32:0] sum;
        page_cnt_t   exp_result;
        sum = {1'b0, model_pages} + {1'b0, n};
        if (sum <= {1'b0, model_max} && sum <= 33'(`WASM_MAX_PAGES)) begin
            exp_result  = model_pages;
            model_pages = sum[31:0];
        end else begin
            exp_result = `WASM_GROW_FAIL;
        end
        @(posedge clk);
        #2;
        mgmt_req.grow_valid = 1'b1;
        mgmt_req.grow_pages = n;
        @(posedge clk);
        #2;
        mgmt_req.grow_valid = 1'b0;
        @(negedge clk);
        check(mgmt_resp.grow_done == 1'b1, "grow_done missing after grow");
        check(mgmt_resp.grow_result == exp_result, "grow result wrong");
        check(mgmt_resp.current_pages == model_pages, "page count wrong after grow");
        @(negedge clk);
        check(mgmt_resp.grow_done == 1'b0, "grow_done longer than one cycle");
    endtask

    task automatic end_test(string name);
        $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("test failed");
        $finish;
    end

    initial begin
        addr_t a;
        mem_req     = '0;
        mgmt_req    = '0;
        lfsr_state  = 16'd46149;
        model_pages = '0;
        model_max   = page_cnt_t'(`WASM_MAX_PAGES);
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        for (int i = 0; i < `WASM_MEM_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end
        @(posedge rst_n);

        // 1: nothing is accessible with zero pages
        @(negedge clk);
        check(mgmt_resp.current_pages == 0, "pages not zero after reset");
        check(mgmt_resp.grow_done == 1'b0, "grow_done set after reset");
        do_load(32'd0, LOAD_I8_U);
        idle();
        end_test("1 reset state");

        // 2: limit ends up at 3 pages
        do_init(32'd2, 32'd3);
        do_grow(32'd1);
        do_grow(32'd1);
        end_test("2 init and grow");

        // Store sizes cycle so every width is written
        for (int i = 0; i < RT_ITERS; i++) begin
            a = addr_t'(rand_bits(10) % 761);
            do_store(a, rand_bits(64), mem_size_e'(i % 4));
            do_load(a, LOAD_I64);
        end
        idle();
        end_test("3 store and load round trip");

        // Sign bits of byte, half and word set so extension shows in the upper bytes
        for (int k = 0; k < 8; k++) begin
            a = addr_t'(rand_bits(10) % 761);
            do_store(a, rand_bits(64) | 64'h0000_0000_8000_8080, SIZE_8);
            do_load(a, load_op_e'(k));
        end
        idle();
        end_test("4 load extension");

        // Limit is 768 bytes here
        do_store(32'd766, rand_bits(64), SIZE_4);
        do_load(32'd760, LOAD_I64);
        do_load(32'd765, LOAD_I32);
        do_load(32'hFFFF_FFFE, LOAD_I32);
        do_store(32'd760, rand_bits(64), SIZE_8);
        do_load(32'd764, LOAD_I32_U);
        do_load(32'd767, LOAD_I8_S);
        idle();
        end_test("5 bounds");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
